//--- rtl/memSys_cfg.svh
`ifndef MEMSYS_CFG_SVH
`define MEMSYS_CFG_SVH

// word and byte address width
`define XLEN 32

// one RAM data byte
`define BYTE_W 8

// access length field, holds 1, 2 or 4
`define LEN_W 3

// RAM address bits, addresses wrap at this depth
`define RAM_AW 16

`define RAM_DEPTH (1 << `RAM_AW)

// bytes per instruction word
`define FETCH_BYTES 4

`endif

//--- rtl/memSysPkg.sv
`include "memSys_cfg.svh"

package memSysPkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`XLEN-1:0]   addr_t;
    typedef logic [`BYTE_W-1:0] byte_t;
    typedef logic [`RAM_AW-1:0] ramAddr_t;
    typedef logic [`LEN_W-1:0]  accLen_t;

    // sequencing of one request in either port
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        FINISH
    } portState_t;

    // current owner of the RAM bus
    typedef enum logic [1:0] {
        FREE,
        FETCH_OWN,
        DATA_OWN
    } arbState_t;

    typedef struct packed {
        addr_t addr;
    } fetchReq_t;

    typedef struct packed {
        logic    isStore;
        accLen_t len;
        addr_t   addr;
        word_t   wdata;
    } dataReq_t;

    // one byte cycle from a port towards the arbiter
    typedef struct packed {
        logic     active;
        logic     last;
        logic     write;
        ramAddr_t addr;
        byte_t    wdata;
    } busReq_t;

endpackage

//--- rtl/fetchPort.sv
`include "memSys_cfg.svh"

module fetchPort
    import memSysPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_stall,
    input  logic      i_en,
    input  fetchReq_t i_req,
    input  logic      i_grant,
    input  byte_t     i_rdata,
    output busReq_t   o_busReq,
    output logic      o_done,
    output word_t     o_inst
);

    portState_t state;
    ramAddr_t   reqAddr;
    logic [2:0] issueCnt;
    logic       rdPend;
    logic       rdLast;
    logic       accept;
    word_t      instAsm;

    // byte reads at addr + 0 .. addr + 3
    always_comb begin
        o_busReq.active = (state == ISSUE) && (issueCnt < 3'(`FETCH_BYTES));
        o_busReq.last   = (issueCnt == 3'(`FETCH_BYTES - 1));
        o_busReq.write  = 1'b0;
        o_busReq.addr   = reqAddr + ramAddr_t'(issueCnt);
        o_busReq.wdata  = '0;
    end

    assign accept = o_busReq.active && i_grant && !i_stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            issueCnt <= '0;
            rdPend   <= 1'b0;
            rdLast   <= 1'b0;
        end else if (!i_stall) begin
            // read data shows up one cycle after the accepted address
            rdPend <= accept;
            rdLast <= accept && o_busReq.last;
            case (state)
                IDLE: begin
                    if (i_en) begin
                        state    <= ISSUE;
                        issueCnt <= '0;
                    end
                end
                ISSUE: begin
                    if (accept) begin
                        issueCnt <= issueCnt + 3'd1;
                    end
                    if (rdPend && rdLast) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            if (state == IDLE && i_en) begin
                reqAddr <= i_req.addr[`RAM_AW-1:0];
            end
            // first byte ends up in the lowest lane after four shifts
            if (rdPend) begin
                instAsm <= {i_rdata, instAsm[`XLEN-1:`BYTE_W]};
            end
        end
    end

    assign o_done = (state == FINISH) && !i_stall;
    assign o_inst = instAsm;

endmodule

//--- rtl/dataPort.sv
`include "memSys_cfg.svh"

module dataPort
    import memSysPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_stall,
    input  logic     i_en,
    input  dataReq_t i_req,
    input  logic     i_grant,
    input  byte_t    i_rdata,
    output busReq_t  o_busReq,
    output logic     o_done,
    output word_t    o_loadData
);

    portState_t state;
    logic       isStore;
    accLen_t    reqLen;
    ramAddr_t   reqAddr;
    word_t      reqData;
    accLen_t    issueCnt;
    logic [1:0] recvIdx;
    logic       rdPend;
    logic       rdLast;
    logic       accept;
    logic       lastWrite;
    word_t      loadAsm;

    // byte index selects the address offset and the store lane
    always_comb begin
        o_busReq.active = (state == ISSUE) && (issueCnt < reqLen);
        o_busReq.last   = (issueCnt == reqLen - accLen_t'(1));
        o_busReq.write  = isStore;
        o_busReq.addr   = reqAddr + ramAddr_t'(issueCnt);
        o_busReq.wdata  = reqData[{issueCnt[1:0], 3'b000} +: `BYTE_W];
    end

    assign accept    = o_busReq.active && i_grant && !i_stall;
    assign lastWrite = accept && isStore && o_busReq.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            issueCnt <= '0;
            recvIdx  <= '0;
            rdPend   <= 1'b0;
            rdLast   <= 1'b0;
        end else if (!i_stall) begin
            rdPend <= accept && !isStore;
            rdLast <= accept && !isStore && o_busReq.last;
            case (state)
                IDLE: begin
                    if (i_en) begin
                        state    <= ISSUE;
                        issueCnt <= '0;
                        recvIdx  <= '0;
                    end
                end
                ISSUE: begin
                    if (accept) begin
                        issueCnt <= issueCnt + accLen_t'(1);
                    end
                    if (rdPend) begin
                        recvIdx <= recvIdx + 2'd1;
                    end
                    // a store is done with its last write, no drain cycle
                    if (lastWrite) begin
                        state <= IDLE;
                    end else if (rdPend && rdLast) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            if (state == IDLE && i_en) begin
                isStore <= i_req.isStore;
                reqLen  <= i_req.len;
                reqAddr <= i_req.addr[`RAM_AW-1:0];
                reqData <= i_req.wdata;
                // lanes above len stay zero
                loadAsm <= '0;
            end else if (rdPend) begin
                loadAsm[{recvIdx, 3'b000} +: `BYTE_W] <= i_rdata;
            end
        end
    end

    assign o_done     = ((state == FINISH) && !i_stall) || lastWrite;
    assign o_loadData = loadAsm;

endmodule

//--- rtl/byteArbiter.sv
module byteArbiter
    import memSysPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_stall,
    input  busReq_t  i_fetchBus,
    input  busReq_t  i_dataBus,
    output logic     o_fetchGrant,
    output logic     o_dataGrant,
    output logic     o_ramWe,
    output ramAddr_t o_ramAddr,
    output byte_t    o_ramWdata
);

    arbState_t state;
    logic      dataSel;
    logic      fetchSel;
    logic      lastAccept;
    busReq_t   selBus;
    ramAddr_t  heldAddr;

    // a free bus goes to the data port first
    always_comb begin
        dataSel  = (state == DATA_OWN) ||
                   ((state == FREE) && i_dataBus.active);
        fetchSel = (state == FETCH_OWN) ||
                   ((state == FREE) && !i_dataBus.active && i_fetchBus.active);
        selBus   = dataSel ? i_dataBus : i_fetchBus;
    end

    assign o_dataGrant  = dataSel;
    assign o_fetchGrant = fetchSel;

    assign lastAccept = selBus.active && selBus.last && !i_stall;

    assign o_ramWe    = selBus.active && selBus.write && !i_stall;
    assign o_ramWdata = selBus.wdata;

    // during a stall the RAM keeps reading the last accepted byte,
    // so a pending read byte is still there when the stall ends
    assign o_ramAddr = i_stall ? heldAddr : selBus.addr;

    always_ff @(posedge clk) begin
        heldAddr <= o_ramAddr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FREE;
        end else if (!i_stall) begin
            if (lastAccept) begin
                state <= FREE;
            end else if (dataSel) begin
                state <= DATA_OWN;
            end else if (fetchSel) begin
                state <= FETCH_OWN;
            end else begin
                state <= FREE;
            end
        end
    end

endmodule

//--- rtl/byteRam.sv
`include "memSys_cfg.svh"

module byteRam
    import memSysPkg::*;
(
    input  logic     clk,
    input  logic     i_we,
    input  ramAddr_t i_addr,
    input  byte_t    i_wdata,
    output byte_t    o_rdata
);

    byte_t mem [`RAM_DEPTH];

    // contents start at zero
    initial begin
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_addr];
    end

endmodule

//--- rtl/memSubsystem.sv
module memSubsystem
    import memSysPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      i_ioFull,
    input  logic      i_fetchEn,
    input  fetchReq_t i_fetchReq,
    output logic      o_fetchDone,
    output word_t     o_inst,
    input  logic      i_dataEn,
    input  dataReq_t  i_dataReq,
    output logic      o_dataDone,
    output word_t     o_loadData
);

    busReq_t  fetchBus;
    busReq_t  dataBus;
    logic     fetchGrant;
    logic     dataGrant;
    logic     ramWe;
    ramAddr_t ramAddr;
    byte_t    ramWdata;
    byte_t    ramRdata;

    fetchPort i_fetchPort (
        .clk      (clk),
        .rst      (rst),
        .i_stall  (i_ioFull),
        .i_en     (i_fetchEn),
        .i_req    (i_fetchReq),
        .i_grant  (fetchGrant),
        .i_rdata  (ramRdata),
        .o_busReq (fetchBus),
        .o_done   (o_fetchDone),
        .o_inst   (o_inst)
    );

    dataPort i_dataPort (
        .clk        (clk),
        .rst        (rst),
        .i_stall    (i_ioFull),
        .i_en       (i_dataEn),
        .i_req      (i_dataReq),
        .i_grant    (dataGrant),
        .i_rdata    (ramRdata),
        .o_busReq   (dataBus),
        .o_done     (o_dataDone),
        .o_loadData (o_loadData)
    );

    byteArbiter i_byteArbiter (
        .clk          (clk),
        .rst          (rst),
        .i_stall      (i_ioFull),
        .i_fetchBus   (fetchBus),
        .i_dataBus    (dataBus),
        .o_fetchGrant (fetchGrant),
        .o_dataGrant  (dataGrant),
        .o_ramWe      (ramWe),
        .o_ramAddr    (ramAddr),
        .o_ramWdata   (ramWdata)
    );

    byteRam i_byteRam (
        .clk     (clk),
        .i_we    (ramWe),
        .i_addr  (ramAddr),
        .i_wdata (ramWdata),
        .o_rdata (ramRdata)
    );

endmodule

//--- testbench/tbClock.sv
module tbClock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- testbench/memSubsystemTb.sv
`include "memSys_cfg.svh"

module memSubsystemTb
    import memSysPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FETCH = 200;
    localparam int NUM_DATA  = 200;
    localparam int TIMEOUT   = (NUM_FETCH + NUM_DATA) * 16 + 1600;

    logic      clk;
    logic      rst;
    logic      ioFull;
    logic      fetchEn;
    fetchReq_t fetchReq;
    logic      fetchDone;
    word_t     inst;
    logic      dataEn;
    dataReq_t  dataReq;
    logic      dataDone;
    word_t     loadData;

    byte_t model [`RAM_DEPTH];
    int    errCount = 0;
    int    checkCount = 0;
    int    cycleCount = 0;
    logic  fetchAllDone = 1'b0;
    logic  dataAllDone = 1'b0;
    time   fetchDoneT;
    time   dataDoneT;

    tbClock clockGen (
        .clk (clk),
        .rst (rst)
    );

    memSubsystem i_dut (
        .clk         (clk),
        .rst         (rst),
        .i_ioFull    (ioFull),
        .i_fetchEn   (fetchEn),
        .i_fetchReq  (fetchReq),
        .o_fetchDone (fetchDone),
        .o_inst      (inst),
        .i_dataEn    (dataEn),
        .i_dataReq   (dataReq),
        .o_dataDone  (dataDone),
        .o_loadData  (loadData)
    );

    task automatic checkEq(input word_t actual, input word_t expected, input string msg);
        checkCount++;
        if (actual !== expected) begin
            errCount++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idleGap();
        repeat ($urandom % 4) stepCycle();
    endtask

    function automatic ramAddr_t wrapAddr(input addr_t addr, input int offset);
        return ramAddr_t'((addr + addr_t'(offset)) % addr_t'(`RAM_DEPTH));
    endfunction

    // little-endian, bytes above len read as zero
    function automatic word_t expectWord(input addr_t addr, input int len);
        word_t w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[8*i +: 8] = model[wrapAddr(addr, i)];
        end
        return w;
    endfunction

    function automatic int randLen();
        int lens [3] = '{1, 2, 4};
        return lens[$urandom % 3];
    endfunction

    // stores stay clear of the fetch window 0xffc0 .. 0x0043
    function automatic addr_t randDataAddr();
        return ($urandom & 32'hFFFF_0000) | (32'h0100 + $urandom % 32'hFE00);
    endfunction

    function automatic addr_t randFetchAddr();
        return ($urandom & 32'hFFFF_0000) | ((32'hFFC0 + $urandom % 128) & 32'hFFFF);
    endfunction

    task automatic runFetch(input addr_t addr);
        word_t expected;
        fetchReq.addr = addr;
        fetchEn = 1'b1;
        do @(negedge clk); while (!fetchDone);
        expected = expectWord(addr, 4);
        checkEq(inst, expected, $sformatf("fetch at %h", addr));
        fetchDoneT = $time;
        stepCycle();
        fetchEn = 1'b0;
    endtask

    task automatic runData(input logic isStore, input int len, input addr_t addr,
                           input word_t wdata);
        word_t expected;
        dataReq.isStore = isStore;
        dataReq.len = accLen_t'(len);
        dataReq.addr = addr;
        dataReq.wdata = wdata;
        dataEn = 1'b1;
        do @(negedge clk); while (!dataDone);
        if (isStore) begin
            for (int i = 0; i < len; i++) begin
                model[wrapAddr(addr, i)] = wdata[8*i +: 8];
            end
        end else begin
            expected = expectWord(addr, len);
            checkEq(loadData, expected, $sformatf("load len %0d at %h", len, addr));
        end
        dataDoneT = $time;
        stepCycle();
        dataEn = 1'b0;
    endtask

    // no done may show while the I/O buffer is full
    always @(negedge clk) begin
        if (!rst && ioFull) begin
            checkEq(word_t'(fetchDone), '0, "fetch done during stall");
            checkEq(word_t'(dataDone), '0, "data done during stall");
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT) begin
            $display("The run timed out after %0d cycles before all tests ended", cycleCount);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        addr_t dirAddr;
        void'($urandom(32'h53f3));
        ioFull = 1'b0;
        fetchEn = 1'b0;
        fetchReq = '0;
        dataEn = 1'b0;
        dataReq = '0;
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            model[i] = '0;
        end
        wait (rst === 1'b0);
        repeat (4) begin
            @(negedge clk);
            checkEq(word_t'(fetchDone), '0, "fetch done after reset");
            checkEq(word_t'(dataDone), '0, "data done after reset");
        end
        stepCycle();

        // fill the fetch window, crossing the RAM top
        for (int i = 0; i < 33; i++) begin
            runData(1'b1, 4, 32'h0000_FFC0 + 32'(4 * i), $urandom);
        end
        runFetch(32'h0000_FFFE);
        runFetch(32'hABCD_FFFD);
        runFetch(32'h1234_FFC0);

        // each store length, then loads of each length
        for (int s = 0; s < 3; s++) begin
            dirAddr = randDataAddr();
            runData(1'b1, (s == 2) ? 4 : s + 1, dirAddr, $urandom);
            runData(1'b0, 1, dirAddr, '0);
            runData(1'b0, 2, dirAddr, '0);
            runData(1'b0, 4, dirAddr, '0);
        end

        // both enables in the same cycle
        fork
            runFetch(randFetchAddr());
            runData(1'b0, 4, randDataAddr(), '0);
        join
        checkEq(word_t'(dataDoneT < fetchDoneT), 32'd1, "data done not before fetch done");

        fork
            begin
                for (int n = 0; n < NUM_FETCH; n++) begin
                    idleGap();
                    runFetch(randFetchAddr());
                end
                fetchAllDone = 1'b1;
            end
            begin
                for (int n = 0; n < NUM_DATA; n++) begin
                    idleGap();
                    runData(1'($urandom % 2), randLen(), randDataAddr(), $urandom);
                end
                dataAllDone = 1'b1;
            end
            begin
                while (!(fetchAllDone && dataAllDone)) begin
                    repeat ($urandom % 12 + 4) stepCycle();
                    ioFull = 1'b1;
                    repeat ($urandom % 4 + 1) stepCycle();
                    ioFull = 1'b0;
                end
            end
        join

        // whole RAM against the model, catches lost or repeated writes
        stepCycle();
        for (int i = 0; i < `RAM_DEPTH; i++) begin
            checkEq(word_t'(i_dut.i_byteRam.mem[i]), word_t'(model[i]),
                    $sformatf("RAM byte %h", i));
        end

        $display("Checks: %0d, errors: %0d, cycles: %0d", checkCount, errCount, cycleCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- memSubsystem.f
+incdir+rtl
rtl/memSysPkg.sv
rtl/fetchPort.sv
rtl/dataPort.sv
rtl/byteArbiter.sv
rtl/byteRam.sv
rtl/memSubsystem.sv
testbench/tbClock.sv
testbench/memSubsystemTb.sv

//--- Makefile
# Verilator simulation of the memory subsystem

VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= memSubsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
